// File: hw/proc_pkg.sv
/*
  Processor package: opcodes, field widths, instruction views and
  memory request type codes for the five-stage pipeline
*/
`default_nettype none

package proc_pkg;

  localparam int xlen       = 32;
  localparam int reg_addr_w = 5;

  // Opcode field values
  localparam logic [5:0] op_special = 6'b000000;
  localparam logic [5:0] op_addiu   = 6'b001001;
  localparam logic [5:0] op_lw      = 6'b100011;
  localparam logic [5:0] op_sw      = 6'b101011;
  localparam logic [5:0] op_bne     = 6'b000101;
  localparam logic [5:0] op_cop0    = 6'b010000;

  localparam logic [5:0] funct_addu = 6'b100001;

  // Direction of a cop0 move, taken from the rs field
  localparam logic [4:0] cop0_mfc0 = 5'b00000;
  localparam logic [4:0] cop0_mtc0 = 5'b00100;

  localparam logic mem_read  = 1'b0;
  localparam logic mem_write = 1'b1;

  localparam logic [xlen-1:0] pc_reset = 32'h0000_0000;

  localparam int fetch_queue_depth = 2;

  // --------------------------------
  // Instruction formats
  // --------------------------------

  typedef struct packed {
    logic [5:0] op;
    logic [4:0] rs;
    logic [4:0] rt;
    logic [4:0] rd;
    logic [4:0] shamt;
    logic [5:0] funct;
  } inst_r_t;

  typedef struct packed {
    logic [5:0]  op;
    logic [4:0]  rs;
    logic [4:0]  rt;
    logic [15:0] imm;
  } inst_i_t;

  typedef union packed {
    inst_r_t r;
    inst_i_t i;
  } inst_t;

endpackage

`default_nettype wire

// File: hw/proc_fetch_queue.sv
/*
  Two-entry bypass FIFO for fetch addresses
*/
`timescale 1ns/1ps
`default_nettype none

module proc_fetch_queue
(
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic [proc_pkg::xlen-1:0] enq_addr,
  input  logic                      enq_val,
  output logic                      enq_rdy,
  output logic [proc_pkg::xlen-1:0] deq_addr,
  output logic                      deq_val,
  input  logic                      deq_rdy
);

  localparam int ptr_w = $clog2(proc_pkg::fetch_queue_depth);

  logic [proc_pkg::xlen-1:0] entries [0:proc_pkg::fetch_queue_depth-1];
  logic [ptr_w-1:0] wr_ptr, rd_ptr;
  logic [ptr_w:0]   count;
  logic             empty, bypass, push, pop;

  assign empty    = count == '0;
  assign enq_rdy  = count != proc_pkg::fetch_queue_depth;
  assign deq_val  = !empty || enq_val;
  assign deq_addr = empty ? enq_addr : entries[rd_ptr];
  // Straight through when nothing is stored
  assign bypass   = empty && enq_val && deq_rdy;
  assign push     = enq_val && enq_rdy && !bypass;
  assign pop      = !empty && deq_rdy;

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
    else
    begin
      if (push)
        wr_ptr <= wr_ptr + 1'b1;
      if (pop)
        rd_ptr <= rd_ptr + 1'b1;
      count <= count + push - pop;
    end
  end

  always_ff @(posedge clk)
  begin
    if (push)
      entries[wr_ptr] <= enq_addr;
  end

  // A push never lands on the oldest stored entry
  a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n)
    push |-> count == '0 || wr_ptr != rd_ptr);

endmodule

`default_nettype wire

// File: hw/proc_drop_unit.sv
/*
  Drops instruction responses that belong to squashed fetches
*/
`timescale 1ns/1ps
`default_nettype none

module proc_drop_unit
(
  input  logic clk,
  input  logic rst_n,
  input  logic squash,
  input  logic in_val,
  output logic in_rdy,
  output logic out_val,
  input  logic out_rdy,
  input  logic req_fire,
  input  logic resp_fire
);

  logic [3:0] outstanding, drop_cnt, outstanding_next;
  logic       drop;

  assign outstanding_next = outstanding + req_fire - resp_fire;
  assign drop    = drop_cnt != '0;
  assign out_val = in_val && !drop;
  assign in_rdy  = drop || out_rdy;

  // Everything in flight at a squash is wrong-path
  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      outstanding <= '0;
      drop_cnt    <= '0;
    end
    else
    begin
      outstanding <= outstanding_next;
      if (squash)
        drop_cnt <= outstanding_next;
      else if (drop && resp_fire)
        drop_cnt <= drop_cnt - 1'b1;
    end
  end

endmodule

`default_nettype wire

// File: hw/proc_ctrl.sv
/*
  Pipeline control: stage valids, decode, scoreboard stalls,
  branch squash and port handshakes
*/
`timescale 1ns/1ps
`default_nettype none

module proc_ctrl
(
  input  logic            clk,
  input  logic            rst_n,
  output logic            fetch_val,
  input  logic            fetch_rdy,
  input  logic            imemresp_val,
  output logic            imemresp_rdy,
  output logic            squash,
  output logic            dmemreq_val,
  input  logic            dmemreq_rdy,
  output logic            dmemreq_type,
  input  logic            dmemresp_val,
  output logic            dmemresp_rdy,
  input  logic            from_mngr_val,
  output logic            from_mngr_rdy,
  output logic            to_mngr_val,
  input  logic            to_mngr_rdy,
  output logic            pc_redirect,
  output logic            reg_en_f,
  output logic            reg_en_d,
  output logic            reg_en_x,
  output logic            reg_en_m,
  output logic            reg_en_w,
  output logic            op1_sel_d,
  output logic            wb_sel_m,
  output logic            mngr_sel_d,
  output logic [proc_pkg::reg_addr_w-1:0] rf_waddr_w,
  output logic            rf_wen_w,
  input  proc_pkg::inst_t inst_d,
  input  logic            br_ne_x
);

  logic go;
  logic val_d, val_x, val_m, val_w, sent_m;
  logic bne_x, mem_x, st_x, mtc0_x, wen_x;
  logic mem_m, st_m, mtc0_m, wen_m;
  logic mtc0_w, wen_w;
  logic [proc_pkg::reg_addr_w-1:0] waddr_x, waddr_m;

  // --------------------------------
  // Decode
  // --------------------------------

  logic is_addu, is_addiu, is_lw, is_sw, is_bne, is_mfc0, is_mtc0;
  logic rs_used, rt_used, wen_d;
  logic [proc_pkg::reg_addr_w-1:0] waddr_d;

  assign is_addu  = inst_d.r.op == proc_pkg::op_special && inst_d.r.funct == proc_pkg::funct_addu;
  assign is_addiu = inst_d.i.op == proc_pkg::op_addiu;
  assign is_lw    = inst_d.i.op == proc_pkg::op_lw;
  assign is_sw    = inst_d.i.op == proc_pkg::op_sw;
  assign is_bne   = inst_d.i.op == proc_pkg::op_bne;
  assign is_mfc0  = inst_d.r.op == proc_pkg::op_cop0 && inst_d.r.rs == proc_pkg::cop0_mfc0;
  assign is_mtc0  = inst_d.r.op == proc_pkg::op_cop0 && inst_d.r.rs == proc_pkg::cop0_mtc0;

  assign rs_used    = is_addu || is_addiu || is_lw || is_sw || is_bne;
  assign rt_used    = is_addu || is_sw || is_bne || is_mtc0;
  assign wen_d      = is_addu || is_addiu || is_lw || is_mfc0;
  // R-type writes rd, I-type and mfc0 write rt
  assign waddr_d    = is_addu ? inst_d.r.rd : inst_d.i.rt;
  assign op1_sel_d  = is_addiu || is_lw || is_sw;
  assign mngr_sel_d = is_mfc0;

  // Scoreboard lookup against writes still in flight
  function automatic logic pending(input logic [proc_pkg::reg_addr_w-1:0] addr);
    pending = (addr != '0) &&
              ((val_x && wen_x && waddr_x == addr) ||
               (val_m && wen_m && waddr_m == addr) ||
               (val_w && wen_w && rf_waddr_w == addr));
  endfunction

  // --------------------------------
  // Stage handshakes
  // --------------------------------

  logic hazard_d, rdy_w_in, m_moves, rdy_m_in, x_moves, rdy_x_in, d_moves;

  assign hazard_d = (rs_used && pending(inst_d.r.rs)) || (rt_used && pending(inst_d.r.rt));

  assign rdy_w_in = !val_w || !mtc0_w || to_mngr_rdy;
  assign m_moves  = val_m && (!mem_m || (sent_m && dmemresp_val)) && rdy_w_in;
  assign rdy_m_in = !val_m || m_moves;
  assign x_moves  = val_x && rdy_m_in;
  assign rdy_x_in = !val_x || rdy_m_in;
  assign squash   = x_moves && bne_x && br_ne_x;
  assign d_moves  = val_d && !hazard_d && (!is_mfc0 || from_mngr_val) && rdy_x_in && !squash;

  assign fetch_val     = go;
  assign imemresp_rdy  = !val_d || d_moves;
  assign from_mngr_rdy = val_d && is_mfc0 && !hazard_d && rdy_x_in && !squash;
  assign dmemreq_val   = val_m && mem_m && !sent_m;
  assign dmemreq_type  = st_m ? proc_pkg::mem_write : proc_pkg::mem_read;
  assign dmemresp_rdy  = val_m && mem_m && sent_m && rdy_w_in;
  assign to_mngr_val   = val_w && mtc0_w;

  assign pc_redirect = squash;
  assign reg_en_f    = (fetch_val && fetch_rdy) || squash;
  assign reg_en_d    = imemresp_val && imemresp_rdy;
  assign reg_en_x    = d_moves;
  assign reg_en_m    = x_moves;
  assign reg_en_w    = m_moves;
  assign wb_sel_m    = mem_m && !st_m;
  assign rf_wen_w    = val_w && wen_w && rdy_w_in;

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      go     <= 1'b0;
      val_d  <= 1'b0;
      val_x  <= 1'b0;
      val_m  <= 1'b0;
      val_w  <= 1'b0;
      sent_m <= 1'b0;
    end
    else
    begin
      go <= 1'b1;
      if (squash)
        val_d <= 1'b0;
      else if (reg_en_d)
        val_d <= 1'b1;
      else if (d_moves)
        val_d <= 1'b0;
      val_x <= d_moves || (val_x && !x_moves);
      val_m <= x_moves || (val_m && !m_moves);
      val_w <= m_moves || (val_w && !rdy_w_in);
      if (m_moves)
        sent_m <= 1'b0;
      else if (dmemreq_val && dmemreq_rdy)
        sent_m <= 1'b1;
    end
  end

  // Control words follow the valid bits down the pipe
  always_ff @(posedge clk)
  begin
    if (reg_en_x)
    begin
      bne_x   <= is_bne;
      mem_x   <= is_lw || is_sw;
      st_x    <= is_sw;
      mtc0_x  <= is_mtc0;
      wen_x   <= wen_d;
      waddr_x <= waddr_d;
    end
    if (reg_en_m)
    begin
      mem_m   <= mem_x;
      st_m    <= st_x;
      mtc0_m  <= mtc0_x;
      wen_m   <= wen_x;
      waddr_m <= waddr_x;
    end
    if (reg_en_w)
    begin
      mtc0_w     <= mtc0_m;
      wen_w      <= wen_m;
      rf_waddr_w <= waddr_m;
    end
  end

  a_to_mngr_hold: assert property (@(posedge clk) disable iff (!rst_n)
    to_mngr_val && !to_mngr_rdy |=> to_mngr_val);

  // No wrong-path instruction is left in D or X after a squash
  a_squash_clears: assert property (@(posedge clk) disable iff (!rst_n)
    squash |=> !val_d && !val_x);

endmodule

`default_nettype wire

// File: hw/proc_dpath.sv
/*
  Datapath: PC, pipeline registers, register file, adder,
  branch compare and memory address and data paths
*/
`timescale 1ns/1ps
`default_nettype none

module proc_dpath
(
  input  logic                      clk,
  input  logic                      rst_n,
  output logic [proc_pkg::xlen-1:0] fetch_addr,
  input  logic [proc_pkg::xlen-1:0] imemresp_data,
  output logic [proc_pkg::xlen-1:0] dmemreq_addr,
  output logic [proc_pkg::xlen-1:0] dmemreq_data,
  input  logic [proc_pkg::xlen-1:0] dmemresp_data,
  input  logic [proc_pkg::xlen-1:0] from_mngr_data,
  output logic [proc_pkg::xlen-1:0] to_mngr_data,
  input  logic                      pc_redirect,
  input  logic                      reg_en_f,
  input  logic                      reg_en_d,
  input  logic                      reg_en_x,
  input  logic                      reg_en_m,
  input  logic                      reg_en_w,
  input  logic                      op1_sel_d,
  input  logic                      wb_sel_m,
  input  logic                      mngr_sel_d,
  input  logic [proc_pkg::reg_addr_w-1:0] rf_waddr_w,
  input  logic                      rf_wen_w,
  output proc_pkg::inst_t           inst_d,
  output logic                      br_ne_x
);

  logic [proc_pkg::xlen-1:0] pc_f, pc_resp, pc_d;
  logic [proc_pkg::xlen-1:0] rf [0:2**proc_pkg::reg_addr_w-1];
  logic [proc_pkg::xlen-1:0] rs_data, rt_data, imm_ext, op_a_d, op_b_d, br_target_d;
  logic [proc_pkg::xlen-1:0] op_a_x, op_b_x, sd_x, br_target_x, sum_x;
  logic [proc_pkg::xlen-1:0] result_m, sd_m, result_w, sd_w;

  // --------------------------------
  // Fetch
  // --------------------------------

  // pc_resp tracks the address of the next response that is kept
  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      pc_f    <= proc_pkg::pc_reset;
      pc_resp <= proc_pkg::pc_reset;
    end
    else
    begin
      if (pc_redirect)
        pc_f <= br_target_x;
      else if (reg_en_f)
        pc_f <= pc_f + 32'd4;
      if (pc_redirect)
        pc_resp <= br_target_x;
      else if (reg_en_d)
        pc_resp <= pc_resp + 32'd4;
    end
  end

  assign fetch_addr = pc_f;

  always_ff @(posedge clk)
  begin
    if (reg_en_d)
    begin
      inst_d <= imemresp_data;
      pc_d   <= pc_resp;
    end
  end

  // --------------------------------
  // Decode and register read
  // --------------------------------

  assign rs_data = (inst_d.r.rs == '0) ? '0 : rf[inst_d.r.rs];
  assign rt_data = (inst_d.r.rt == '0) ? '0 : rf[inst_d.r.rt];
  assign imm_ext = {{16{inst_d.i.imm[15]}}, inst_d.i.imm};

  // mfc0 passes the manager word through the adder with a zero operand
  assign op_a_d      = mngr_sel_d ? from_mngr_data : rs_data;
  assign op_b_d      = mngr_sel_d ? '0 : (op1_sel_d ? imm_ext : rt_data);
  assign br_target_d = pc_d + 32'd4 + (imm_ext << 2);

  always_ff @(posedge clk)
  begin
    if (reg_en_x)
    begin
      op_a_x      <= op_a_d;
      op_b_x      <= op_b_d;
      sd_x        <= rt_data;
      br_target_x <= br_target_d;
    end
  end

  // Execute
  assign sum_x   = op_a_x + op_b_x;
  assign br_ne_x = op_a_x != op_b_x;

  always_ff @(posedge clk)
  begin
    if (reg_en_m)
    begin
      result_m <= sum_x;
      sd_m     <= sd_x;
    end
    if (reg_en_w)
    begin
      result_w <= wb_sel_m ? dmemresp_data : result_m;
      sd_w     <= sd_m;
    end
  end

  assign dmemreq_addr = result_m;
  assign dmemreq_data = sd_m;
  assign to_mngr_data = sd_w;

  // Register file write in W, r0 never written
  always_ff @(posedge clk)
  begin
    if (rf_wen_w && rf_waddr_w != '0)
      rf[rf_waddr_w] <= result_w;
  end

endmodule

`default_nettype wire

// File: hw/pipelined_proc.sv
/*
  Five-stage pipelined processor top: control, datapath,
  fetch request queue and fetch response drop unit
*/
`timescale 1ns/1ps
`default_nettype none

module pipelined_proc
(
  input  logic                      clk,
  input  logic                      rst_n,

  output logic [proc_pkg::xlen-1:0] imemreq_addr,
  output logic                      imemreq_val,
  input  logic                      imemreq_rdy,

  input  logic [proc_pkg::xlen-1:0] imemresp_data,
  input  logic                      imemresp_val,
  output logic                      imemresp_rdy,

  output logic                      dmemreq_type,
  output logic [proc_pkg::xlen-1:0] dmemreq_addr,
  output logic [proc_pkg::xlen-1:0] dmemreq_data,
  output logic                      dmemreq_val,
  input  logic                      dmemreq_rdy,

  input  logic [proc_pkg::xlen-1:0] dmemresp_data,
  input  logic                      dmemresp_val,
  output logic                      dmemresp_rdy,

  input  logic [proc_pkg::xlen-1:0] from_mngr_data,
  input  logic                      from_mngr_val,
  output logic                      from_mngr_rdy,

  output logic [proc_pkg::xlen-1:0] to_mngr_data,
  output logic                      to_mngr_val,
  input  logic                      to_mngr_rdy
);

  // Fetch side
  logic [proc_pkg::xlen-1:0] fetch_addr;
  logic                      fetch_val;
  logic                      fetch_rdy;
  logic                      squash;
  logic                      imemresp_val_f;
  logic                      imemresp_rdy_f;

  // Control to datapath
  logic pc_redirect;
  logic reg_en_f, reg_en_d, reg_en_x, reg_en_m, reg_en_w;
  logic op1_sel_d, wb_sel_m, mngr_sel_d;
  logic [proc_pkg::reg_addr_w-1:0] rf_waddr_w;
  logic rf_wen_w;

  // Datapath status
  proc_pkg::inst_t inst_d;
  logic            br_ne_x;

  proc_ctrl i_proc_ctrl
  (
    .clk            (clk),
    .rst_n          (rst_n),
    .fetch_val      (fetch_val),
    .fetch_rdy      (fetch_rdy),
    .imemresp_val   (imemresp_val_f),
    .imemresp_rdy   (imemresp_rdy_f),
    .squash         (squash),
    .dmemreq_val    (dmemreq_val),
    .dmemreq_rdy    (dmemreq_rdy),
    .dmemreq_type   (dmemreq_type),
    .dmemresp_val   (dmemresp_val),
    .dmemresp_rdy   (dmemresp_rdy),
    .from_mngr_val  (from_mngr_val),
    .from_mngr_rdy  (from_mngr_rdy),
    .to_mngr_val    (to_mngr_val),
    .to_mngr_rdy    (to_mngr_rdy),
    .pc_redirect    (pc_redirect),
    .reg_en_f       (reg_en_f),
    .reg_en_d       (reg_en_d),
    .reg_en_x       (reg_en_x),
    .reg_en_m       (reg_en_m),
    .reg_en_w       (reg_en_w),
    .op1_sel_d      (op1_sel_d),
    .wb_sel_m       (wb_sel_m),
    .mngr_sel_d     (mngr_sel_d),
    .rf_waddr_w     (rf_waddr_w),
    .rf_wen_w       (rf_wen_w),
    .inst_d         (inst_d),
    .br_ne_x        (br_ne_x)
  );

  proc_dpath i_proc_dpath
  (
    .clk            (clk),
    .rst_n          (rst_n),
    .fetch_addr     (fetch_addr),
    .imemresp_data  (imemresp_data),
    .dmemreq_addr   (dmemreq_addr),
    .dmemreq_data   (dmemreq_data),
    .dmemresp_data  (dmemresp_data),
    .from_mngr_data (from_mngr_data),
    .to_mngr_data   (to_mngr_data),
    .pc_redirect    (pc_redirect),
    .reg_en_f       (reg_en_f),
    .reg_en_d       (reg_en_d),
    .reg_en_x       (reg_en_x),
    .reg_en_m       (reg_en_m),
    .reg_en_w       (reg_en_w),
    .op1_sel_d      (op1_sel_d),
    .wb_sel_m       (wb_sel_m),
    .mngr_sel_d     (mngr_sel_d),
    .rf_waddr_w     (rf_waddr_w),
    .rf_wen_w       (rf_wen_w),
    .inst_d         (inst_d),
    .br_ne_x        (br_ne_x)
  );

  proc_fetch_queue i_proc_fetch_queue
  (
    .clk      (clk),
    .rst_n    (rst_n),
    .enq_addr (fetch_addr),
    .enq_val  (fetch_val),
    .enq_rdy  (fetch_rdy),
    .deq_addr (imemreq_addr),
    .deq_val  (imemreq_val),
    .deq_rdy  (imemreq_rdy)
  );

  proc_drop_unit i_proc_drop_unit
  (
    .clk       (clk),
    .rst_n     (rst_n),
    .squash    (squash),
    .in_val    (imemresp_val),
    .in_rdy    (imemresp_rdy),
    .out_val   (imemresp_val_f),
    .out_rdy   (imemresp_rdy_f),
    .req_fire  (fetch_val && fetch_rdy),
    .resp_fire (imemresp_val && imemresp_rdy)
  );

endmodule

`default_nettype wire

// File: testbench/tb_clock.sv
/*
  Testbench clock source, 100 ns period
*/
`timescale 1ns/1ps
`default_nettype none

module tb_clock
(
  output logic clk
);

  initial
  begin
    clk = 1'b0;
    forever
      #50 clk = ~clk;
  end

endmodule

`default_nettype wire

// File: testbench/tb_pipelined_proc.sv
/*
  Testbench for the pipelined processor: memory models with random
  latency, manager source and sink, and a table of operand rows
*/
`timescale 1ns/1ps
`default_nettype none

module tb_pipelined_proc;

  localparam int num_rows    = 8;
  localparam int imem_words  = 64;
  localparam int dmem_words  = 128;
  localparam int max_pending = 2;
  localparam int row_timeout = 1000;
  localparam logic [31:0] data_addr = 32'h0000_0100;

  // Operand rows where several sums wrap at 32 bits
  localparam logic [31:0] table_a [0:num_rows-1] = '{
    32'h0000_0001, 32'h0000_0010, 32'hFFFF_FFFF, 32'h8000_0000,
    32'h1234_5678, 32'h0000_0000, 32'h7FFF_FFFF, 32'hDEAD_BEEF};
  localparam logic [31:0] table_b [0:num_rows-1] = '{
    32'h0000_0002, 32'h0000_0020, 32'h0000_0002, 32'h8000_0000,
    32'h1111_1111, 32'h0000_0000, 32'h0000_0001, 32'h2152_4110};

  logic        clk, rst_n;
  logic [31:0] imemreq_addr, imemresp_data, dmemreq_addr, dmemreq_data, dmemresp_data;
  logic        imemreq_val, imemreq_rdy, imemresp_val, imemresp_rdy;
  logic        dmemreq_type, dmemreq_val, dmemreq_rdy, dmemresp_val, dmemresp_rdy;
  logic [31:0] from_mngr_data, to_mngr_data;
  logic        from_mngr_val, from_mngr_rdy, to_mngr_val, to_mngr_rdy;

  logic [31:0] imem [0:imem_words-1];
  logic [31:0] dmem [0:dmem_words-1];
  logic [31:0] imem_data_q [$];
  int          imem_due_q [$];
  logic [31:0] dmem_data_q [$];
  int          dmem_due_q [$];
  logic [31:0] src_q [$];
  logic [31:0] sink_q [$];
  logic [15:0] lfsr_state;
  logic [31:0] cur_sum;
  int          cycle_count;
  logic        first_fetch_seen;

  tb_clock i_tb_clock (.clk(clk));

  pipelined_proc i_pipelined_proc
  (
    .clk            (clk),
    .rst_n          (rst_n),
    .imemreq_addr   (imemreq_addr),
    .imemreq_val    (imemreq_val),
    .imemreq_rdy    (imemreq_rdy),
    .imemresp_data  (imemresp_data),
    .imemresp_val   (imemresp_val),
    .imemresp_rdy   (imemresp_rdy),
    .dmemreq_type   (dmemreq_type),
    .dmemreq_addr   (dmemreq_addr),
    .dmemreq_data   (dmemreq_data),
    .dmemreq_val    (dmemreq_val),
    .dmemreq_rdy    (dmemreq_rdy),
    .dmemresp_data  (dmemresp_data),
    .dmemresp_val   (dmemresp_val),
    .dmemresp_rdy   (dmemresp_rdy),
    .from_mngr_data (from_mngr_data),
    .from_mngr_val  (from_mngr_val),
    .from_mngr_rdy  (from_mngr_rdy),
    .to_mngr_data   (to_mngr_data),
    .to_mngr_val    (to_mngr_val),
    .to_mngr_rdy    (to_mngr_rdy)
  );

  // ------------------------------
  // Helpers
  // ------------------------------

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("FAIL: see errors above");
    $fatal(1, "Simulation stopped");
  endtask

  task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                             input string what);
    if (actual !== expected)
    begin
      $display("error at %0t: %s: got 0x%08h, expected 0x%08h",
               $time, what, actual, expected);
      $display("FAIL: see errors above");
      $fatal(1, "Stopped at first mismatch");
    end
  endtask

  // Galois LFSR, one step per bit taken
  function automatic logic random_bit();
    logic out;
    out = lfsr_state[0];
    lfsr_state = lfsr_state >> 1;
    if (out)
      lfsr_state = lfsr_state ^ 16'hB400;
    return out;
  endfunction

  function automatic int random_delay();
    logic [1:0] d;
    d[0] = random_bit();
    d[1] = random_bit();
    return int'(d);
  endfunction

  function automatic logic [31:0] make_r_type(input logic [5:0] op, input logic [4:0] rs,
                                              input logic [4:0] rt, input logic [4:0] rd,
                                              input logic [5:0] funct);
    proc_pkg::inst_t inst;
    inst.r.op    = op;
    inst.r.rs    = rs;
    inst.r.rt    = rt;
    inst.r.rd    = rd;
    inst.r.shamt = 5'd0;
    inst.r.funct = funct;
    return inst;
  endfunction

  function automatic logic [31:0] make_i_type(input logic [5:0] op, input logic [4:0] rs,
                                              input logic [4:0] rt, input logic [15:0] imm);
    proc_pkg::inst_t inst;
    inst.i.op  = op;
    inst.i.rs  = rs;
    inst.i.rt  = rt;
    inst.i.imm = imm;
    return inst;
  endfunction

  task automatic load_memories();
    int i;
    // Spare words are mtc0 r0 tagged with their address, so a stray one reaches the sink
    for (i = 0; i < imem_words; i++)
      imem[i] = {proc_pkg::op_cop0, proc_pkg::cop0_mtc0, 5'd0, 16'(i * 4)};
    for (i = 0; i < dmem_words; i++)
      dmem[i] = 32'hC0DE_0000 ^ 32'(i * 4);
    imem[0] = make_r_type(proc_pkg::op_cop0, proc_pkg::cop0_mfc0, 5'd1, 5'd0, 6'd0);
    imem[1] = make_r_type(proc_pkg::op_cop0, proc_pkg::cop0_mfc0, 5'd2, 5'd0, 6'd0);
    imem[2] = make_r_type(proc_pkg::op_special, 5'd1, 5'd2, 5'd3, proc_pkg::funct_addu);
    imem[3] = make_i_type(proc_pkg::op_sw, 5'd0, 5'd3, data_addr[15:0]);
    imem[4] = make_i_type(proc_pkg::op_lw, 5'd0, 5'd4, data_addr[15:0]);
    imem[5] = make_i_type(proc_pkg::op_addiu, 5'd4, 5'd5, 16'd1);
    imem[6] = make_r_type(proc_pkg::op_cop0, proc_pkg::cop0_mtc0, 5'd4, 5'd0, 6'd0);
    imem[7] = make_r_type(proc_pkg::op_cop0, proc_pkg::cop0_mtc0, 5'd5, 5'd0, 6'd0);
    // Taken on every pass since r5 is r4 plus one
    imem[8] = make_i_type(proc_pkg::op_bne, 5'd4, 5'd5, 16'hFFF7);
  endtask

  // ------------------------------
  // Per-cycle models
  // ------------------------------

  task automatic drive_inputs();
    imemreq_rdy   = imem_data_q.size() < max_pending;
    imemresp_val  = 1'b0;
    imemresp_data = '0;
    if (imem_data_q.size() > 0 && imem_due_q[0] <= cycle_count)
    begin
      imemresp_val  = 1'b1;
      imemresp_data = imem_data_q[0];
    end
    dmemreq_rdy   = dmem_data_q.size() < max_pending;
    dmemresp_val  = 1'b0;
    dmemresp_data = '0;
    if (dmem_data_q.size() > 0 && dmem_due_q[0] <= cycle_count)
    begin
      dmemresp_val  = 1'b1;
      dmemresp_data = dmem_data_q[0];
    end
    from_mngr_val  = src_q.size() > 0;
    from_mngr_data = (src_q.size() > 0) ? src_q[0] : '0;
    to_mngr_rdy    = random_bit();
  endtask

  // Transfers that the next rising edge will perform
  task automatic observe_transfers();
    if (imemreq_val && imemreq_rdy)
    begin
      if (!first_fetch_seen)
        check_value(imemreq_addr, proc_pkg::pc_reset, "first fetch address");
      first_fetch_seen = 1'b1;
      if (imemreq_addr[1:0] != 2'b00 || imemreq_addr >= 32'(imem_words * 4))
        report_failure($sformatf("Fetch from 0x%08h lies outside program memory",
                                 imemreq_addr));
      imem_data_q.push_back(imem[imemreq_addr[7:2]]);
      imem_due_q.push_back(cycle_count + 1 + random_delay());
    end
    if (imemresp_val && imemresp_rdy)
    begin
      void'(imem_data_q.pop_front());
      void'(imem_due_q.pop_front());
    end
    if (dmemreq_val && dmemreq_rdy)
    begin
      if (dmemreq_type == proc_pkg::mem_write)
      begin
        check_value(dmemreq_addr, data_addr, "store address");
        check_value(dmemreq_data, cur_sum, "store data");
        dmem[dmemreq_addr[8:2]] = dmemreq_data;
        dmem_data_q.push_back('0);
      end
      else
      begin
        check_value(dmemreq_addr, data_addr, "load address");
        dmem_data_q.push_back(dmem[dmemreq_addr[8:2]]);
      end
      dmem_due_q.push_back(cycle_count + 1 + random_delay());
    end
    if (dmemresp_val && dmemresp_rdy)
    begin
      void'(dmem_data_q.pop_front());
      void'(dmem_due_q.pop_front());
    end
    if (from_mngr_val && from_mngr_rdy)
      void'(src_q.pop_front());
    if (to_mngr_val && to_mngr_rdy)
      sink_q.push_back(to_mngr_data);
  endtask

  task step_cycle();
    @(negedge clk);
    cycle_count++;
    drive_inputs();
    #1;
    observe_transfers();
  endtask

  task wait_for_outputs(input int count);
    int cycles;
    cycles = 0;
    while (sink_q.size() < count && cycles < row_timeout)
    begin
      step_cycle();
      cycles++;
    end
    if (sink_q.size() < count)
      report_failure($sformatf("Timed out after %0d cycles waiting for manager output %0d",
                               cycles, count));
  endtask

  // ------------------------------
  // Test sequence
  // ------------------------------

  initial
  begin
    rst_n            = 1'b0;
    imemreq_rdy      = 1'b1;
    imemresp_val     = 1'b0;
    imemresp_data    = '0;
    dmemreq_rdy      = 1'b1;
    dmemresp_val     = 1'b0;
    dmemresp_data    = '0;
    from_mngr_val    = 1'b0;
    from_mngr_data   = '0;
    to_mngr_rdy      = 1'b0;
    lfsr_state       = 16'd32041;
    cur_sum          = '0;
    cycle_count      = 0;
    first_fetch_seen = 1'b0;
    load_memories();

    repeat (2) @(negedge clk);
    rst_n = 1'b1;
    #1;
    check_value(32'(to_mngr_val), 32'd0, "to_mngr_val after reset");
    check_value(32'(dmemreq_val), 32'd0, "dmemreq_val after reset");
    check_value(32'(imemreq_val), 32'd0, "imemreq_val after reset");

    for (int row = 0; row < num_rows; row++)
    begin
      cur_sum = table_a[row] + table_b[row];
      src_q.push_back(table_a[row]);
      src_q.push_back(table_b[row]);
      wait_for_outputs(2 * (row + 1));
      check_value(sink_q[2 * row], cur_sum, $sformatf("row %0d loaded sum", row));
      check_value(sink_q[2 * row + 1], cur_sum + 32'd1,
                  $sformatf("row %0d incremented sum", row));
    end

    // Pipe idles on the next mfc0 and sends nothing more
    repeat (40) step_cycle();
    check_value(32'(sink_q.size()), 32'(2 * num_rows), "to_mngr transfer count");

    $display("PASS: all tests");
    $finish;
  end

endmodule

`default_nettype wire

// File: pipelined_proc.f
hw/proc_pkg.sv
hw/proc_fetch_queue.sv
hw/proc_drop_unit.sv
hw/proc_ctrl.sv
hw/proc_dpath.sv
hw/pipelined_proc.sv
testbench/tb_clock.sv
testbench/tb_pipelined_proc.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build the pipelined_proc testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_pipelined_proc -f pipelined_proc.f --Mdir obj_dir
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

output=$(./obj_dir/Vtb_pipelined_proc 2>&1)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if echo "$output" | grep -qx "PASS: all tests"; then
  exit 0
else
  echo "Pass line not found in simulation output"
  exit 1
fi
